//--- rtl/tile_pkg.sv
package tile_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int XLEN          = 32;
  localparam int PHY_NUM       = 32;
  localparam int PHY_W         = 5;
  localparam int ROB_SIZE      = 8;
  localparam int CMT_ID_W      = 3;
  localparam int IQ_SIZE       = 4;
  // Slot index and age width inside an issue queue
  localparam int IQ_IDX_W      = 2;
  // Two read ports per execution unit
  localparam int RD_PORT_NUM   = 4;
  localparam int DONE_PORT_NUM = 2;

  // ------------------------------
  // Categories and opcodes
  // ------------------------------
  typedef enum logic {CAT_ALU, CAT_BR} inst_cat_t;

  typedef enum logic [1:0] {OP_ADD, OP_SUB, OP_AND, OP_XOR} alu_op_t;

  // BR_LT is a signed compare
  typedef enum logic {BR_EQ, BR_LT} br_op_t;

  typedef struct packed {
    alu_op_t               op;
    logic [PHY_W-1:0]      rd;
    logic [CMT_ID_W-1:0]   cmt_id;
  } alu_payload_t;

  typedef struct packed {
    br_op_t                op;
    logic                  pred_taken;
    logic [CMT_ID_W-1:0]   cmt_id;
  } br_payload_t;

  typedef struct packed {
    logic                  valid;
    logic [CMT_ID_W-1:0]   cmt_id;
    logic [XLEN-1:0]       data;
    logic                  taken;
    logic                  mispred;
  } done_rpt_t;

endpackage

//--- rtl/issue_queue.sv
`timescale 1ns/1ps

module issue_queue #(
  parameter type T_PAYLOAD = tile_pkg::alu_payload_t
) (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  logic                       i_write,
  input  T_PAYLOAD                   i_payload,
  input  logic [tile_pkg::PHY_W-1:0] i_rs1,
  input  logic [tile_pkg::PHY_W-1:0] i_rs2,
  input  logic                       i_rs1_ready,
  input  logic                       i_rs2_ready,
  input  logic                       i_wb_valid,
  input  logic [tile_pkg::PHY_W-1:0] i_wb_rd,
  output logic                       o_full,
  output logic                       o_issue_valid,
  output T_PAYLOAD                   o_issue_payload,
  output logic [tile_pkg::PHY_W-1:0] o_issue_rs1,
  output logic [tile_pkg::PHY_W-1:0] o_issue_rs2
);

  typedef logic [tile_pkg::IQ_IDX_W-1:0] idx_t;

  logic [tile_pkg::IQ_SIZE-1:0] r_valid;
  logic [tile_pkg::IQ_SIZE-1:0] r_rs1_rdy;
  logic [tile_pkg::IQ_SIZE-1:0] r_rs2_rdy;
  idx_t                         r_age [tile_pkg::IQ_SIZE];
  T_PAYLOAD                     r_payload [tile_pkg::IQ_SIZE];
  logic [tile_pkg::PHY_W-1:0]   r_rs1 [tile_pkg::IQ_SIZE];
  logic [tile_pkg::PHY_W-1:0]   r_rs2 [tile_pkg::IQ_SIZE];

  logic [tile_pkg::IQ_SIZE-1:0] w_ready;
  idx_t                         w_sel;
  idx_t                         w_free;
  logic [tile_pkg::IQ_IDX_W:0]  w_count;
  logic                         w_new_rs1_rdy;
  logic                         w_new_rs2_rdy;

  assign w_ready       = r_valid & r_rs1_rdy & r_rs2_rdy;
  assign o_full        = &r_valid;
  // Bypass a write-back that lands in the dispatch cycle
  assign w_new_rs1_rdy = i_rs1_ready | (i_wb_valid && i_wb_rd == i_rs1);
  assign w_new_rs2_rdy = i_rs2_ready | (i_wb_valid && i_wb_rd == i_rs2);

  // Oldest ready entry has the smallest age
  always_comb begin
    o_issue_valid = 1'b0;
    w_sel         = '0;
    w_free        = '0;
    w_count       = '0;
    for (int i = tile_pkg::IQ_SIZE - 1; i >= 0; i--) begin
      if (!r_valid[i]) begin
        w_free = idx_t'(i);
      end
      w_count = w_count + r_valid[i];
    end
    for (int i = 0; i < tile_pkg::IQ_SIZE; i++) begin
      if (w_ready[i] && (!o_issue_valid || r_age[i] < r_age[w_sel])) begin
        o_issue_valid = 1'b1;
        w_sel         = idx_t'(i);
      end
    end
  end

  assign o_issue_payload = r_payload[w_sel];
  assign o_issue_rs1     = r_rs1[w_sel];
  assign o_issue_rs2     = r_rs2[w_sel];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_valid   <= '0;
      r_rs1_rdy <= '0;
      r_rs2_rdy <= '0;
      for (int i = 0; i < tile_pkg::IQ_SIZE; i++) begin
        r_age[i] <= '0;
      end
    end else begin
      for (int i = 0; i < tile_pkg::IQ_SIZE; i++) begin
        if (r_valid[i]) begin
          // Wakeup from the write-back bus
          if (i_wb_valid && r_rs1[i] == i_wb_rd) begin
            r_rs1_rdy[i] <= 1'b1;
          end
          if (i_wb_valid && r_rs2[i] == i_wb_rd) begin
            r_rs2_rdy[i] <= 1'b1;
          end
          // Younger entries move up when an older one leaves
          if (o_issue_valid && r_age[i] > r_age[w_sel]) begin
            r_age[i] <= r_age[i] - 1'b1;
          end
        end
      end
      if (o_issue_valid) begin
        r_valid[w_sel] <= 1'b0;
      end
      if (i_write) begin
        r_valid[w_free]   <= 1'b1;
        r_rs1_rdy[w_free] <= w_new_rs1_rdy;
        r_rs2_rdy[w_free] <= w_new_rs2_rdy;
        r_age[w_free]     <= idx_t'(w_count - o_issue_valid);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_write) begin
      r_payload[w_free] <= i_payload;
      r_rs1[w_free]     <= i_rs1;
      r_rs2[w_free]     <= i_rs2;
    end
  end

endmodule

//--- rtl/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  input  logic                          i_disp,
  input  logic [1:0]                    i_op,
  input  logic [tile_pkg::PHY_W-1:0]    i_rd,
  input  logic [tile_pkg::PHY_W-1:0]    i_rs1,
  input  logic [tile_pkg::PHY_W-1:0]    i_rs2,
  input  logic [tile_pkg::CMT_ID_W-1:0] i_cmt_id,
  input  logic                          i_rs1_ready,
  input  logic                          i_rs2_ready,
  input  logic                          i_wb_valid,
  input  logic [tile_pkg::PHY_W-1:0]    i_wb_rd,
  input  logic [tile_pkg::XLEN-1:0]     i_rs1_data,
  input  logic [tile_pkg::XLEN-1:0]     i_rs2_data,
  output logic                          o_full,
  output logic [tile_pkg::PHY_W-1:0]    o_rs1_idx,
  output logic [tile_pkg::PHY_W-1:0]    o_rs2_idx,
  output logic                          o_wb_valid,
  output logic [tile_pkg::PHY_W-1:0]    o_wb_rd,
  output logic [tile_pkg::XLEN-1:0]     o_wb_data,
  output tile_pkg::done_rpt_t           o_done_rpt
);

  tile_pkg::alu_payload_t          w_disp_payload;
  tile_pkg::alu_payload_t          w_iss_payload;
  logic                            w_iss_valid;
  logic [tile_pkg::XLEN-1:0]       w_result;

  logic                            r_valid;
  logic [tile_pkg::PHY_W-1:0]      r_rd;
  logic [tile_pkg::CMT_ID_W-1:0]   r_cmt_id;
  logic [tile_pkg::XLEN-1:0]       r_result;

  assign w_disp_payload.op     = tile_pkg::alu_op_t'(i_op);
  assign w_disp_payload.rd     = i_rd;
  assign w_disp_payload.cmt_id = i_cmt_id;

  issue_queue #(
    .T_PAYLOAD(tile_pkg::alu_payload_t)
  ) u_alu_iq (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_write        (i_disp),
    .i_payload      (w_disp_payload),
    .i_rs1          (i_rs1),
    .i_rs2          (i_rs2),
    .i_rs1_ready    (i_rs1_ready),
    .i_rs2_ready    (i_rs2_ready),
    .i_wb_valid     (i_wb_valid),
    .i_wb_rd        (i_wb_rd),
    .o_full         (o_full),
    .o_issue_valid  (w_iss_valid),
    .o_issue_payload(w_iss_payload),
    .o_issue_rs1    (o_rs1_idx),
    .o_issue_rs2    (o_rs2_idx)
  );

  // ------------------------------
  // Execute
  // ------------------------------
  always_comb begin
    case (w_iss_payload.op)
      tile_pkg::OP_ADD: w_result = i_rs1_data + i_rs2_data;
      tile_pkg::OP_SUB: w_result = i_rs1_data - i_rs2_data;
      tile_pkg::OP_AND: w_result = i_rs1_data & i_rs2_data;
      tile_pkg::OP_XOR: w_result = i_rs1_data ^ i_rs2_data;
      default:          w_result = '0;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= w_iss_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_rd     <= w_iss_payload.rd;
    r_cmt_id <= w_iss_payload.cmt_id;
    r_result <= w_result;
  end

  assign o_wb_valid = r_valid;
  assign o_wb_rd    = r_rd;
  assign o_wb_data  = r_result;

  always_comb begin
    o_done_rpt         = '0;
    o_done_rpt.valid   = r_valid;
    o_done_rpt.cmt_id  = r_cmt_id;
    o_done_rpt.data    = r_result;
  end

endmodule

//--- rtl/bru_unit.sv
`timescale 1ns/1ps

module bru_unit (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  input  logic                          i_disp,
  input  logic                          i_op,
  input  logic                          i_pred_taken,
  input  logic [tile_pkg::PHY_W-1:0]    i_rs1,
  input  logic [tile_pkg::PHY_W-1:0]    i_rs2,
  input  logic [tile_pkg::CMT_ID_W-1:0] i_cmt_id,
  input  logic                          i_rs1_ready,
  input  logic                          i_rs2_ready,
  input  logic                          i_wb_valid,
  input  logic [tile_pkg::PHY_W-1:0]    i_wb_rd,
  input  logic [tile_pkg::XLEN-1:0]     i_rs1_data,
  input  logic [tile_pkg::XLEN-1:0]     i_rs2_data,
  output logic                          o_full,
  output logic [tile_pkg::PHY_W-1:0]    o_rs1_idx,
  output logic [tile_pkg::PHY_W-1:0]    o_rs2_idx,
  output tile_pkg::done_rpt_t           o_done_rpt
);

  tile_pkg::br_payload_t           w_disp_payload;
  tile_pkg::br_payload_t           w_iss_payload;
  logic                            w_iss_valid;
  logic                            w_taken;

  logic                            r_valid;
  logic [tile_pkg::CMT_ID_W-1:0]   r_cmt_id;
  logic                            r_taken;
  logic                            r_mispred;

  assign w_disp_payload.op         = tile_pkg::br_op_t'(i_op);
  assign w_disp_payload.pred_taken = i_pred_taken;
  assign w_disp_payload.cmt_id     = i_cmt_id;

  issue_queue #(
    .T_PAYLOAD(tile_pkg::br_payload_t)
  ) u_br_iq (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_write        (i_disp),
    .i_payload      (w_disp_payload),
    .i_rs1          (i_rs1),
    .i_rs2          (i_rs2),
    .i_rs1_ready    (i_rs1_ready),
    .i_rs2_ready    (i_rs2_ready),
    .i_wb_valid     (i_wb_valid),
    .i_wb_rd        (i_wb_rd),
    .o_full         (o_full),
    .o_issue_valid  (w_iss_valid),
    .o_issue_payload(w_iss_payload),
    .o_issue_rs1    (o_rs1_idx),
    .o_issue_rs2    (o_rs2_idx)
  );

  // Branch condition
  always_comb begin
    case (w_iss_payload.op)
      tile_pkg::BR_EQ: w_taken = (i_rs1_data == i_rs2_data);
      tile_pkg::BR_LT: w_taken = ($signed(i_rs1_data) < $signed(i_rs2_data));
      default:         w_taken = 1'b0;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= w_iss_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_cmt_id  <= w_iss_payload.cmt_id;
    r_taken   <= w_taken;
    r_mispred <= w_taken ^ w_iss_payload.pred_taken;
  end

  // No register result, so data stays zero
  always_comb begin
    o_done_rpt         = '0;
    o_done_rpt.valid   = r_valid;
    o_done_rpt.cmt_id  = r_cmt_id;
    o_done_rpt.taken   = r_taken;
    o_done_rpt.mispred = r_mispred;
  end

endmodule

//--- rtl/phy_registers.sv
`timescale 1ns/1ps

module phy_registers (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  input  logic                         i_alloc,
  input  logic [tile_pkg::PHY_W-1:0]   i_alloc_rd,
  input  logic                         i_wb_valid,
  input  logic [tile_pkg::PHY_W-1:0]   i_wb_rd,
  input  logic [tile_pkg::XLEN-1:0]    i_wb_data,
  input  logic [tile_pkg::PHY_W-1:0]   i_rd_idx [tile_pkg::RD_PORT_NUM],
  output logic [tile_pkg::PHY_NUM-1:0] o_ready_vec,
  output logic [tile_pkg::XLEN-1:0]    o_rd_data [tile_pkg::RD_PORT_NUM]
);

  logic [tile_pkg::XLEN-1:0]    r_data [tile_pkg::PHY_NUM];
  logic [tile_pkg::PHY_NUM-1:0] r_ready;

  // Registers read zero after reset
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_ready <= '1;
      for (int i = 0; i < tile_pkg::PHY_NUM; i++) begin
        r_data[i] <= '0;
      end
    end else begin
      if (i_wb_valid) begin
        r_data[i_wb_rd]  <= i_wb_data;
        r_ready[i_wb_rd] <= 1'b1;
      end
      // A new producer of the same register wins
      if (i_alloc) begin
        r_ready[i_alloc_rd] <= 1'b0;
      end
    end
  end

  assign o_ready_vec = r_ready;

  always_comb begin
    for (int p = 0; p < tile_pkg::RD_PORT_NUM; p++) begin
      o_rd_data[p] = (i_wb_valid && i_wb_rd == i_rd_idx[p]) ? i_wb_data : r_data[i_rd_idx[p]];
    end
  end

endmodule

//--- rtl/rob.sv
`timescale 1ns/1ps

module rob (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  input  logic                          i_alloc,
  input  tile_pkg::inst_cat_t           i_alloc_cat,
  input  logic [tile_pkg::PHY_W-1:0]    i_alloc_rd,
  input  tile_pkg::done_rpt_t           i_done_rpt [tile_pkg::DONE_PORT_NUM],
  output logic                          o_full,
  output logic [tile_pkg::CMT_ID_W-1:0] o_new_cmt_id,
  output logic                          o_commit_valid,
  output logic [tile_pkg::CMT_ID_W-1:0] o_commit_cmt_id,
  output tile_pkg::inst_cat_t           o_commit_cat,
  output logic [tile_pkg::PHY_W-1:0]    o_commit_rd,
  output logic [tile_pkg::XLEN-1:0]     o_commit_data,
  output logic                          o_commit_taken,
  output logic                          o_commit_mispred
);

  logic [tile_pkg::CMT_ID_W-1:0] r_head;
  logic [tile_pkg::CMT_ID_W-1:0] r_tail;
  logic [tile_pkg::CMT_ID_W:0]   r_count;
  logic [tile_pkg::ROB_SIZE-1:0] r_done;

  tile_pkg::inst_cat_t           r_cat     [tile_pkg::ROB_SIZE];
  logic [tile_pkg::PHY_W-1:0]    r_rd      [tile_pkg::ROB_SIZE];
  logic [tile_pkg::XLEN-1:0]     r_data    [tile_pkg::ROB_SIZE];
  logic [tile_pkg::ROB_SIZE-1:0] r_taken;
  logic [tile_pkg::ROB_SIZE-1:0] r_mispred;

  logic                          w_commit;

  assign o_full       = (r_count == tile_pkg::ROB_SIZE);
  assign o_new_cmt_id = r_tail;
  assign w_commit     = (r_count != '0) && r_done[r_head];

  // ------------------------------
  // Pointers and completion
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_head         <= '0;
      r_tail         <= '0;
      r_count        <= '0;
      r_done         <= '0;
      o_commit_valid <= 1'b0;
    end else begin
      for (int p = 0; p < tile_pkg::DONE_PORT_NUM; p++) begin
        if (i_done_rpt[p].valid) begin
          r_done[i_done_rpt[p].cmt_id] <= 1'b1;
        end
      end
      if (i_alloc) begin
        r_done[r_tail] <= 1'b0;
        r_tail         <= r_tail + 1'b1;
      end
      if (w_commit) begin
        r_head <= r_head + 1'b1;
      end
      r_count        <= r_count + i_alloc - w_commit;
      o_commit_valid <= w_commit;
    end
  end

  // ------------------------------
  // Entry payload and commit data
  // ------------------------------
  always_ff @(posedge i_clk) begin
    if (i_alloc) begin
      r_cat[r_tail] <= i_alloc_cat;
      r_rd[r_tail]  <= i_alloc_rd;
    end
    for (int p = 0; p < tile_pkg::DONE_PORT_NUM; p++) begin
      if (i_done_rpt[p].valid) begin
        r_data[i_done_rpt[p].cmt_id]    <= i_done_rpt[p].data;
        r_taken[i_done_rpt[p].cmt_id]   <= i_done_rpt[p].taken;
        r_mispred[i_done_rpt[p].cmt_id] <= i_done_rpt[p].mispred;
      end
    end
    o_commit_cmt_id  <= r_head;
    o_commit_cat     <= r_cat[r_head];
    o_commit_rd      <= r_rd[r_head];
    o_commit_data    <= r_data[r_head];
    o_commit_taken   <= r_taken[r_head];
    o_commit_mispred <= r_mispred[r_head];
  end

endmodule

//--- rtl/core_tile.sv
`timescale 1ns/1ps

module core_tile (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  input  logic                          i_disp_valid,
  input  tile_pkg::inst_cat_t           i_disp_cat,
  input  logic [1:0]                    i_disp_op,
  input  logic [tile_pkg::PHY_W-1:0]    i_disp_rs1,
  input  logic [tile_pkg::PHY_W-1:0]    i_disp_rs2,
  input  logic [tile_pkg::PHY_W-1:0]    i_disp_rd,
  input  logic                          i_disp_pred_taken,
  output logic                          o_disp_ready,
  output logic                          o_commit_valid,
  output logic [tile_pkg::CMT_ID_W-1:0] o_commit_cmt_id,
  output tile_pkg::inst_cat_t           o_commit_cat,
  output logic [tile_pkg::PHY_W-1:0]    o_commit_rd,
  output logic [tile_pkg::XLEN-1:0]     o_commit_data,
  output logic                          o_commit_taken,
  output logic                          o_commit_mispred
);

  logic                          w_rob_full;
  logic                          w_alu_full;
  logic                          w_br_full;
  logic                          w_disp_fire;
  logic                          w_alu_disp;
  logic                          w_br_disp;
  logic [tile_pkg::CMT_ID_W-1:0] w_new_cmt_id;
  logic [tile_pkg::PHY_W-1:0]    w_rob_rd;
  logic [tile_pkg::PHY_NUM-1:0]  w_ready_vec;

  // ------------------------------
  // Merged write-back / done buses
  // ------------------------------
  logic                          w_wb_valid;
  logic [tile_pkg::PHY_W-1:0]    w_wb_rd;
  logic [tile_pkg::XLEN-1:0]     w_wb_data;
  logic [tile_pkg::PHY_W-1:0]    w_rd_idx  [tile_pkg::RD_PORT_NUM];
  logic [tile_pkg::XLEN-1:0]     w_rd_data [tile_pkg::RD_PORT_NUM];
  tile_pkg::done_rpt_t           w_alu_done_rpt;
  tile_pkg::done_rpt_t           w_br_done_rpt;
  tile_pkg::done_rpt_t           w_done_rpt [tile_pkg::DONE_PORT_NUM];

  // Category routing
  assign o_disp_ready = !w_rob_full &&
                        ((i_disp_cat == tile_pkg::CAT_ALU) ? !w_alu_full : !w_br_full);
  assign w_disp_fire  = i_disp_valid && o_disp_ready;
  assign w_alu_disp   = w_disp_fire && (i_disp_cat == tile_pkg::CAT_ALU);
  assign w_br_disp    = w_disp_fire && (i_disp_cat == tile_pkg::CAT_BR);
  // Branches carry no rd
  assign w_rob_rd     = (i_disp_cat == tile_pkg::CAT_BR) ? '0 : i_disp_rd;

  assign w_done_rpt[0] = w_alu_done_rpt;
  assign w_done_rpt[1] = w_br_done_rpt;

  alu_unit u_alu (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_disp     (w_alu_disp),
    .i_op       (i_disp_op),
    .i_rd       (i_disp_rd),
    .i_rs1      (i_disp_rs1),
    .i_rs2      (i_disp_rs2),
    .i_cmt_id   (w_new_cmt_id),
    .i_rs1_ready(w_ready_vec[i_disp_rs1]),
    .i_rs2_ready(w_ready_vec[i_disp_rs2]),
    .i_wb_valid (w_wb_valid),
    .i_wb_rd    (w_wb_rd),
    .i_rs1_data (w_rd_data[0]),
    .i_rs2_data (w_rd_data[1]),
    .o_full     (w_alu_full),
    .o_rs1_idx  (w_rd_idx[0]),
    .o_rs2_idx  (w_rd_idx[1]),
    .o_wb_valid (w_wb_valid),
    .o_wb_rd    (w_wb_rd),
    .o_wb_data  (w_wb_data),
    .o_done_rpt (w_alu_done_rpt)
  );

  bru_unit u_bru (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_disp      (w_br_disp),
    .i_op        (i_disp_op[0]),
    .i_pred_taken(i_disp_pred_taken),
    .i_rs1       (i_disp_rs1),
    .i_rs2       (i_disp_rs2),
    .i_cmt_id    (w_new_cmt_id),
    .i_rs1_ready (w_ready_vec[i_disp_rs1]),
    .i_rs2_ready (w_ready_vec[i_disp_rs2]),
    .i_wb_valid  (w_wb_valid),
    .i_wb_rd     (w_wb_rd),
    .i_rs1_data  (w_rd_data[2]),
    .i_rs2_data  (w_rd_data[3]),
    .o_full      (w_br_full),
    .o_rs1_idx   (w_rd_idx[2]),
    .o_rs2_idx   (w_rd_idx[3]),
    .o_done_rpt  (w_br_done_rpt)
  );

  phy_registers u_phy_registers (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_alloc    (w_alu_disp),
    .i_alloc_rd (i_disp_rd),
    .i_wb_valid (w_wb_valid),
    .i_wb_rd    (w_wb_rd),
    .i_wb_data  (w_wb_data),
    .i_rd_idx   (w_rd_idx),
    .o_ready_vec(w_ready_vec),
    .o_rd_data  (w_rd_data)
  );

  rob u_rob (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_alloc         (w_disp_fire),
    .i_alloc_cat     (i_disp_cat),
    .i_alloc_rd      (w_rob_rd),
    .i_done_rpt      (w_done_rpt),
    .o_full          (w_rob_full),
    .o_new_cmt_id    (w_new_cmt_id),
    .o_commit_valid  (o_commit_valid),
    .o_commit_cmt_id (o_commit_cmt_id),
    .o_commit_cat    (o_commit_cat),
    .o_commit_rd     (o_commit_rd),
    .o_commit_data   (o_commit_data),
    .o_commit_taken  (o_commit_taken),
    .o_commit_mispred(o_commit_mispred)
  );

endmodule

//--- tb/tile_asserts.sv
`timescale 1ns/1ps

module tile_asserts (
  input logic                          i_clk,
  input logic                          i_rst_n,
  input logic                          i_alloc,
  input logic                          i_full,
  input logic                          i_commit_valid,
  input logic [tile_pkg::CMT_ID_W-1:0] i_commit_cmt_id
);

  int                            fail_count = 0;
  logic                          r_seen;
  logic [tile_pkg::CMT_ID_W-1:0] r_last;
  logic [tile_pkg::CMT_ID_W-1:0] w_next_id;
  logic [tile_pkg::CMT_ID_W:0]   r_occupancy;

  // Wraps at ROB_SIZE since the ID is CMT_ID_W bits wide
  assign w_next_id = r_last + 1'b1;

  // Entries allocated and not yet seen on the commit outputs
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_seen      <= 1'b0;
      r_last      <= '0;
      r_occupancy <= '0;
    end else begin
      if (i_commit_valid) begin
        r_seen <= 1'b1;
        r_last <= i_commit_cmt_id;
      end
      r_occupancy <= r_occupancy + i_alloc - i_commit_valid;
    end
  end

  a_cmt_id_in_order: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_commit_valid && r_seen) |-> (i_commit_cmt_id == w_next_id))
    else begin
      $error("Commit ID does not follow the previous one");
      fail_count++;
    end

  a_no_alloc_when_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_full && i_alloc))
    else begin
      $error("Allocation while the reorder buffer is full");
      fail_count++;
    end

  a_no_commit_when_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_commit_valid |-> (r_occupancy != '0))
    else begin
      $error("Commit from an empty reorder buffer");
      fail_count++;
    end

endmodule

bind rob tile_asserts u_tile_asserts (
  .i_clk          (i_clk),
  .i_rst_n        (i_rst_n),
  .i_alloc        (i_alloc),
  .i_full         (o_full),
  .i_commit_valid (o_commit_valid),
  .i_commit_cmt_id(o_commit_cmt_id)
);

//--- tb/tile_tb.sv
`timescale 1ns/1ps

module tile_tb;

  localparam int CLK_HALF        = 20;
  localparam int DRIVE_DELAY     = 2;
  localparam int RESET_CYCLES    = 2;
  localparam int REC_WORDS       = 12;
  localparam int CYCLES_PER_REC  = 20;
  localparam int PAT_DEPTH       = 256;

  logic                          i_clk;
  logic                          i_rst_n;
  logic                          i_disp_valid;
  tile_pkg::inst_cat_t           i_disp_cat;
  logic [1:0]                    i_disp_op;
  logic [tile_pkg::PHY_W-1:0]    i_disp_rs1;
  logic [tile_pkg::PHY_W-1:0]    i_disp_rs2;
  logic [tile_pkg::PHY_W-1:0]    i_disp_rd;
  logic                          i_disp_pred_taken;
  logic                          o_disp_ready;
  logic                          o_commit_valid;
  logic [tile_pkg::CMT_ID_W-1:0] o_commit_cmt_id;
  tile_pkg::inst_cat_t           o_commit_cat;
  logic [tile_pkg::PHY_W-1:0]    o_commit_rd;
  logic [tile_pkg::XLEN-1:0]     o_commit_data;
  logic                          o_commit_taken;
  logic                          o_commit_mispred;

  // Word 0 is the record count, then REC_WORDS words per record
  logic [31:0] pat [0:PAT_DEPTH-1];
  int          n_rec;
  int          n_committed;
  logic        loaded;
  logic [31:0] rand_state;

  core_tile core_tile_i (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_disp_valid     (i_disp_valid),
    .i_disp_cat       (i_disp_cat),
    .i_disp_op        (i_disp_op),
    .i_disp_rs1       (i_disp_rs1),
    .i_disp_rs2       (i_disp_rs2),
    .i_disp_rd        (i_disp_rd),
    .i_disp_pred_taken(i_disp_pred_taken),
    .o_disp_ready     (o_disp_ready),
    .o_commit_valid   (o_commit_valid),
    .o_commit_cmt_id  (o_commit_cmt_id),
    .o_commit_cat     (o_commit_cat),
    .o_commit_rd      (o_commit_rd),
    .o_commit_data    (o_commit_data),
    .o_commit_taken   (o_commit_taken),
    .o_commit_mispred (o_commit_mispred)
  );

  initial begin
    i_clk = 1'b0;
    forever #CLK_HALF i_clk = ~i_clk;
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  function automatic logic [31:0] next_rand_state(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("Error at %0t ns: %s expected %0h, actual %0h",
                         $time, name, expected, actual));
    end
  endtask

  // Hold one record on the dispatch port until it is accepted
  task automatic dispatch_record(input int idx);
    int   base;
    logic accepted;
    base              = 1 + idx * REC_WORDS;
    accepted          = 1'b0;
    i_disp_valid      = 1'b1;
    i_disp_cat        = tile_pkg::inst_cat_t'(pat[base][0]);
    i_disp_op         = pat[base + 1][1:0];
    i_disp_rs1        = pat[base + 2][tile_pkg::PHY_W-1:0];
    i_disp_rs2        = pat[base + 3][tile_pkg::PHY_W-1:0];
    i_disp_rd         = pat[base + 4][tile_pkg::PHY_W-1:0];
    i_disp_pred_taken = pat[base + 5][0];
    while (!accepted) begin
      @(negedge i_clk);
      accepted = o_disp_ready;
      @(posedge i_clk);
      #DRIVE_DELAY;
    end
    i_disp_valid = 1'b0;
  endtask

  task automatic compare_commit(input int idx);
    int base;
    base = 1 + idx * REC_WORDS + 6;
    check_value("o_commit_cmt_id", pat[base], o_commit_cmt_id);
    check_value("o_commit_cat", pat[base + 1], o_commit_cat);
    check_value("o_commit_rd", pat[base + 2], o_commit_rd);
    check_value("o_commit_data", pat[base + 3], o_commit_data);
    check_value("o_commit_taken", pat[base + 4], o_commit_taken);
    check_value("o_commit_mispred", pat[base + 5], o_commit_mispred);
  endtask

  // ------------------------------
  // Stimulus and verdict
  // ------------------------------
  initial begin
    int gap;
    i_rst_n           = 1'b0;
    i_disp_valid      = 1'b0;
    i_disp_cat        = tile_pkg::CAT_ALU;
    i_disp_op         = '0;
    i_disp_rs1        = '0;
    i_disp_rs2        = '0;
    i_disp_rd         = '0;
    i_disp_pred_taken = 1'b0;
    n_committed       = 0;
    loaded            = 1'b0;
    rand_state        = 32'd4353;
    $readmemh("tb/tile_patterns.txt", pat);
    n_rec  = pat[0];
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge i_clk);
    #DRIVE_DELAY;
    i_rst_n = 1'b1;
    // Empty tile accepts dispatch
    @(negedge i_clk);
    check_value("o_disp_ready", 32'd1, o_disp_ready);
    @(posedge i_clk);
    #DRIVE_DELAY;
    for (int k = 0; k < n_rec; k++) begin
      rand_state = next_rand_state(rand_state);
      gap        = rand_state[1:0];
      repeat (gap) begin
        @(posedge i_clk);
        #DRIVE_DELAY;
      end
      dispatch_record(k);
    end
    wait (n_committed == n_rec);
    // A few more cycles to catch stray commits
    repeat (5) @(posedge i_clk);
    if (core_tile_i.u_rob.u_tile_asserts.fail_count == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      fail_run("The reorder buffer assertions reported failures during the run");
    end
  end

  // Commit outputs are stable at the falling edge
  always @(negedge i_clk) begin
    if (core_tile_i.u_rob.u_tile_asserts.fail_count != 0) begin
      fail_run("A reorder buffer assertion failed");
    end else if (i_rst_n && o_commit_valid) begin
      if (n_committed >= n_rec) begin
        fail_run("A commit arrived after the whole expected stream had committed");
      end else begin
        compare_commit(n_committed);
        n_committed = n_committed + 1;
      end
    end
  end

  initial begin
    wait (loaded);
    repeat (RESET_CYCLES + n_rec * CYCLES_PER_REC) @(posedge i_clk);
    fail_run($sformatf("Watchdog expired, commits stopped arriving after %0d of %0d records",
                       n_committed, n_rec));
  end

endmodule

//--- tb/tile_patterns.txt
// Per line: cat op rs1 rs2 rd pred_taken, then the expected commit: cmt_id cat rd data taken mispred
// The first word is the record count in hex; registers never written read zero
10
0 0 00 00 01 0   0 0 01 00000000 0 0
0 1 01 01 02 0   1 0 02 00000000 0 0
0 2 02 01 03 0   2 0 03 00000000 0 0
0 3 03 02 04 0   3 0 04 00000000 0 0
1 0 1f 1e 00 0   4 1 00 00000000 1 1
1 1 04 03 00 1   5 1 00 00000000 0 1
0 0 04 04 05 0   6 0 05 00000000 0 0
0 1 05 05 06 0   7 0 06 00000000 0 0
0 3 06 05 07 0   0 0 07 00000000 0 0
1 0 07 06 00 1   1 1 00 00000000 1 0
1 1 07 00 00 0   2 1 00 00000000 0 0
1 0 1d 1c 00 1   3 1 00 00000000 1 0
0 2 07 06 08 0   4 0 08 00000000 0 0
0 0 08 07 09 0   5 0 09 00000000 0 0
1 1 09 08 00 1   6 1 00 00000000 0 1
0 3 1a 1b 0a 0   7 0 0a 00000000 0 0

//--- list.f
rtl/tile_pkg.sv
rtl/issue_queue.sv
rtl/alu_unit.sv
rtl/bru_unit.sv
rtl/phy_registers.sv
rtl/rob.sv
rtl/core_tile.sv
tb/tile_asserts.sv
tb/tile_tb.sv

//--- Bender.yml
package:
  name: core_tile

sources:
  - rtl/tile_pkg.sv
  - rtl/issue_queue.sv
  - rtl/alu_unit.sv
  - rtl/bru_unit.sv
  - rtl/phy_registers.sv
  - rtl/rob.sv
  - rtl/core_tile.sv
  - target: test
    files:
      - tb/tile_asserts.sv
      - tb/tile_tb.sv
